//--- common/trap_config.svh
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing of the trap subsystem.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// width of one data word, used for addresses and CSR values.
`define TRAP_XLEN 32

// number of level interrupt lines seen by the arbiter.
`define TRAP_NUM_IRQ 8

// index of the line that is served without waiting for the pipeline.
// lower indexes win, so the fast line is also the most urgent one.
`define TRAP_FAST_IRQ 0

`endif

//--- common/trap_pkg.sv
`include "trap_config.svh"

package trap_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic words.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned CAUSE_CODE_W = 5;  // width of the mcause code field.

    typedef logic [`TRAP_XLEN-1:0]  data_word_t;   // addresses and CSR values.
    typedef logic [CAUSE_CODE_W-1:0] cause_code_t; // exception or interrupt number.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // trap records.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // contents of mcause, the bits above these two fields read as zero.
    typedef struct packed {
        logic        is_interrupt;  // set for asynchronous causes.
        cause_code_t code;          // exception code or interrupt line number.
    } cause_t;

    // request from the arbiter to the trap manager.
    // fast and code are held stable for as long as req is high.
    typedef struct packed {
        logic        req;   // four-phase request, dropped after ack.
        logic        fast;  // the line may be served without draining the pipeline.
        cause_code_t code;  // interrupt number of the chosen line.
    } irq_req_t;

    // jump order for the fetch unit.
    typedef struct packed {
        logic       valid;   // the fetch unit takes target as the next pc.
        data_word_t target;  // handler entry or the saved mepc.
    } pc_redirect_t;

endpackage : trap_pkg

//--- hdl/irq_arbiter.sv
`timescale 1ns/1ps
`include "trap_config.svh"

module irq_arbiter
    import trap_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`TRAP_NUM_IRQ-1:0] irq_i,      // level interrupt lines.
    output irq_req_t                 irq_req_o,  // request towards the trap manager.
    input  logic                     irq_ack_i   // four-phase acknowledge.
);

    localparam int unsigned IDX_W = $clog2(`TRAP_NUM_IRQ);

    logic [`TRAP_NUM_IRQ-1:0] irq_q;                 // lines as seen last cycle.
    logic [`TRAP_NUM_IRQ-1:0] pending_q, pending_d;  // one bit per line waiting service.
    logic [`TRAP_NUM_IRQ-1:0] clear_mask;            // line retired by the handshake.
    logic [IDX_W-1:0]         sel_idx;               // lowest pending line.
    irq_req_t                 req_q, req_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // priority selection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // scan from the top down so that the lowest pending index is left last.
    always_comb begin
        sel_idx = '0;
        for (int i = `TRAP_NUM_IRQ - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request side of the handshake.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        req_d      = req_q;  // the choice is frozen while req is up.
        clear_mask = '0;
        if (req_q.req) begin
            if (irq_ack_i) begin
                clear_mask[req_q.code[IDX_W-1:0]] = 1'b1;  // line has been taken.
                req_d.req                         = 1'b0;
            end
        end else if (!irq_ack_i && (pending_q != '0)) begin
            // a new request only once the previous ack has gone low.
            req_d.req  = 1'b1;
            req_d.fast = (sel_idx == IDX_W'(`TRAP_FAST_IRQ));
            req_d.code = cause_code_t'(sel_idx);
        end
    end

    // a rising line sets its bit even while a request is in flight.
    assign pending_d = (pending_q & ~clear_mask) | (irq_i & ~irq_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            irq_q     <= '0;
            pending_q <= '0;
            req_q     <= '0;
        end else begin
            irq_q     <= irq_i;
            pending_q <= pending_d;
            req_q     <= req_d;
        end
    end

    assign irq_req_o = req_q;

endmodule : irq_arbiter

//--- trap/trap_csr.sv
`timescale 1ns/1ps
`include "trap_config.svh"

module trap_csr
    import trap_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  data_word_t mtvec_i,        // new trap vector base.
    input  logic       mtvec_we_i,     // loads mtvec_i.
    input  logic       capture_i,      // a trap is being taken this cycle.
    input  cause_t     cause_i,        // cause written into mcause on capture.
    input  data_word_t epc_i,          // address written into mepc on capture.
    input  cause_t     offer_cause_i,  // cause the manager is about to serve.
    output data_word_t handler_pc_o,   // entry point for offer_cause_i.
    output data_word_t mepc_o,
    output cause_t     mcause_o
);

    data_word_t mepc_q;
    data_word_t mtvec_q;
    cause_t     mcause_q;
    data_word_t vector_base;    // mtvec with the mode bits masked off.
    data_word_t vector_offset;  // four bytes per interrupt number.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // machine trap registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtvec_q  <= '0;
        end else begin
            if (capture_i) begin
                mepc_q   <= epc_i;    // where to resume after the handler.
                mcause_q <= cause_i;  // why the trap was taken.
            end
            if (mtvec_we_i) begin
                mtvec_q <= mtvec_i;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handler address.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the two low bits of mtvec hold the mode and never reach the pc.
    assign vector_base   = {mtvec_q[`TRAP_XLEN-1:2], 2'b00};
    assign vector_offset = data_word_t'(offer_cause_i.code) << 2;

    // exceptions share the base, interrupts land in their own slot.
    assign handler_pc_o = offer_cause_i.is_interrupt ? vector_base + vector_offset
                                                     : vector_base;

    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

endmodule : trap_csr

//--- trap/trap_manager.sv
`timescale 1ns/1ps

module trap_manager
    import trap_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  irq_req_t     irq_req_i,          // request from the arbiter.
    output logic         irq_ack_o,          // acknowledge towards the arbiter.
    input  logic         exception_i,        // synchronous exception from the pipeline.
    input  data_word_t   exception_addr_i,   // address of the faulting instruction.
    input  cause_code_t  exception_code_i,
    input  logic         core_sleep_i,       // the exception is a wait-for-interrupt.
    input  logic         pipeline_empty_i,
    input  data_word_t   current_pc_i,       // resume point for an interrupt.
    input  logic         return_instr_i,     // return-from-trap in execution.
    input  data_word_t   jump_addr_i,        // target of that return.
    input  data_word_t   mepc_i,
    input  data_word_t   handler_pc_i,       // entry point for offer_cause_o.
    output logic         capture_o,          // write mepc and mcause.
    output cause_t       cause_o,
    output data_word_t   epc_o,
    output cause_t       offer_cause_o,
    output logic         flush_o,
    output logic         stall_o,
    output logic         block_front_end_o,
    output pc_redirect_t redirect_o
);

    typedef enum logic [1:0] {IDLE, ACK, WAIT, SLEEP} state_t;

    state_t      state_q, state_d;
    logic        exc_kept_q, exc_kept_d;    // an exception waits for the next IDLE.
    data_word_t  kept_addr_q, kept_addr_d;
    cause_code_t kept_code_q, kept_code_d;
    logic        keep_exc;                  // park exception_i this cycle.
    logic        trap_redirect;             // jump to the handler this cycle.
    logic        ret_match;                 // return to the saved mepc.
    cause_t      trap_cause;
    data_word_t  trap_epc;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            exc_kept_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            exc_kept_q <= exc_kept_d;
        end
    end

    always_ff @(posedge clk_i) begin
        kept_addr_q <= kept_addr_d;
        kept_code_q <= kept_code_d;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d           = state_q;
        exc_kept_d        = exc_kept_q;
        kept_addr_d       = kept_addr_q;
        kept_code_d       = kept_code_q;
        keep_exc          = 1'b0;
        trap_redirect     = 1'b0;
        flush_o           = 1'b0;
        stall_o           = 1'b0;
        block_front_end_o = 1'b0;
        irq_ack_o         = 1'b0;
        trap_cause        = '{is_interrupt: 1'b1, code: irq_req_i.code};
        trap_epc          = current_pc_i;  // interrupts resume where the pc stands.

        case (state_q)
            IDLE: begin
                if (exc_kept_q) begin
                    // the parked exception goes first, a request waits a cycle.
                    trap_cause    = '{is_interrupt: 1'b0, code: kept_code_q};
                    trap_epc      = kept_addr_q;
                    trap_redirect = 1'b1;
                    exc_kept_d    = 1'b0;
                    keep_exc      = exception_i;
                end else if (irq_req_i.req && irq_req_i.fast) begin
                    trap_redirect = 1'b1;  // no need to drain the pipeline.
                    keep_exc      = exception_i;
                    state_d       = ACK;
                end else if (irq_req_i.req) begin
                    keep_exc = exception_i;
                    flush_o  = exception_i;
                    state_d  = WAIT;       // let the older instructions retire.
                end else if (exception_i) begin
                    if (core_sleep_i) begin
                        stall_o = 1'b1;    // the whole core waits for an interrupt.
                        state_d = SLEEP;
                    end else begin
                        trap_cause    = '{is_interrupt: 1'b0, code: exception_code_i};
                        trap_epc      = exception_addr_i;
                        trap_redirect = 1'b1;
                    end
                end
                // stop fetching as soon as anything wants a trap.
                block_front_end_o = irq_req_i.req | exception_i | exc_kept_q;
            end

            ACK: begin
                irq_ack_o         = 1'b1;  // held until the arbiter drops req.
                block_front_end_o = 1'b1;
                keep_exc          = exception_i;
                if (!irq_req_i.req) begin
                    state_d = IDLE;
                end
            end

            WAIT: begin
                block_front_end_o = 1'b1;
                keep_exc          = exception_i;
                flush_o           = exception_i;  // squash it now, serve it later.
                if (pipeline_empty_i) begin
                    trap_redirect = 1'b1;
                    state_d       = ACK;
                end
            end

            SLEEP: begin
                stall_o = 1'b1;
                if (irq_req_i.req) begin
                    state_d = IDLE;  // the request is served from IDLE.
                end
            end

            default: state_d = IDLE;
        endcase

        // only one exception is parked, a second one is dropped.
        if (keep_exc && !exc_kept_d) begin
            exc_kept_d  = 1'b1;
            kept_addr_d = exception_addr_i;
            kept_code_d = exception_code_i;
        end

        if (trap_redirect) begin
            flush_o = 1'b1;  // every handler entry empties the pipeline.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CSR side and pc redirect.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign capture_o     = trap_redirect;
    assign cause_o       = trap_cause;
    assign epc_o         = trap_epc;
    assign offer_cause_o = trap_cause;  // the CSR block turns it into handler_pc_i.

    assign ret_match = return_instr_i & (jump_addr_i == mepc_i);

    // a return to the saved mepc leaves the handler from any state.
    assign redirect_o.valid  = trap_redirect | ret_match;
    assign redirect_o.target = trap_redirect ? handler_pc_i : mepc_i;

endmodule : trap_manager

//--- hdl/trap_unit.sv
`timescale 1ns/1ps
`include "trap_config.svh"

module trap_unit
    import trap_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`TRAP_NUM_IRQ-1:0] irq_i,
    input  logic                     exception_i,
    input  data_word_t               exception_addr_i,
    input  cause_code_t              exception_code_i,
    input  logic                     core_sleep_i,
    input  logic                     pipeline_empty_i,
    input  data_word_t               current_pc_i,
    input  logic                     return_instr_i,
    input  data_word_t               jump_addr_i,
    input  data_word_t               mtvec_i,
    input  logic                     mtvec_we_i,
    output logic                     flush_o,
    output logic                     stall_o,
    output logic                     block_front_end_o,
    output pc_redirect_t             redirect_o,
    output cause_t                   mcause_o
);

    irq_req_t   irq_req;      // arbiter request.
    logic       irq_ack;      // four-phase acknowledge.
    logic       capture;      // trap entry strobe for the CSRs.
    cause_t     cause;
    cause_t     offer_cause;  // cause used for the handler lookup.
    data_word_t epc;
    data_word_t handler_pc;
    data_word_t mepc;

    irq_arbiter arbiter_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .irq_i     (irq_i),
        .irq_req_o (irq_req),
        .irq_ack_i (irq_ack)
    );

    trap_manager manager_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .irq_req_i         (irq_req),
        .irq_ack_o         (irq_ack),
        .exception_i       (exception_i),
        .exception_addr_i  (exception_addr_i),
        .exception_code_i  (exception_code_i),
        .core_sleep_i      (core_sleep_i),
        .pipeline_empty_i  (pipeline_empty_i),
        .current_pc_i      (current_pc_i),
        .return_instr_i    (return_instr_i),
        .jump_addr_i       (jump_addr_i),
        .mepc_i            (mepc),
        .handler_pc_i      (handler_pc),
        .capture_o         (capture),
        .cause_o           (cause),
        .epc_o             (epc),
        .offer_cause_o     (offer_cause),
        .flush_o           (flush_o),
        .stall_o           (stall_o),
        .block_front_end_o (block_front_end_o),
        .redirect_o        (redirect_o)
    );

    trap_csr csr_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mtvec_i       (mtvec_i),
        .mtvec_we_i    (mtvec_we_i),
        .capture_i     (capture),
        .cause_i       (cause),
        .epc_i         (epc),
        .offer_cause_i (offer_cause),
        .handler_pc_o  (handler_pc),
        .mepc_o        (mepc),
        .mcause_o      (mcause_o)
    );

endmodule : trap_unit

//--- testbench/trap_unit_chk.sv
`timescale 1ns/1ps

module trap_unit_chk
    import trap_pkg::*;
(
    input logic         clk_i,
    input logic         rst_n_i,
    input irq_req_t     irq_req_i,
    input logic         irq_ack_i,
    input logic         flush_i,
    input logic         stall_i,
    input logic         block_front_end_i,
    input pc_redirect_t redirect_i
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // four-phase handshake.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(irq_ack_i) |-> irq_req_i.req)
        else $error("irq ack rose while no request was up");

    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_req_i.req && !irq_ack_i |=> irq_req_i.req)
        else $error("irq request dropped before it was acknowledged");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one reset edge clears the state, from then on all is quiet.
    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i && $past(!rst_n_i) |-> !flush_i && !stall_i && !block_front_end_i
                                         && !redirect_i.valid && !irq_ack_i && !irq_req_i.req)
        else $error("trap outputs active during reset");

    stall_no_jump: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> !redirect_i.valid)
        else $error("pc redirect while the core is stalled");

endmodule : trap_unit_chk

bind trap_manager trap_unit_chk chk_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .irq_req_i         (irq_req_i),
    .irq_ack_i         (irq_ack_o),
    .flush_i           (flush_o),
    .stall_i           (stall_o),
    .block_front_end_i (block_front_end_o),
    .redirect_i        (redirect_o)
);

//--- testbench/trap_unit_tb.sv
`timescale 1ns/1ps
`include "trap_config.svh"

module trap_unit_tb
    import trap_pkg::*;
();

    localparam int TIMEOUT     = 60;  // cycles any single wait may take.
    localparam int ARB_LATENCY = 2;   // edges from a rising line to the arbiter request.

    logic                     clk_i = 1'b0;
    logic                     rst_n_i;
    logic [`TRAP_NUM_IRQ-1:0] irq_i;
    logic                     exception_i;
    data_word_t               exception_addr_i;
    cause_code_t              exception_code_i;
    logic                     core_sleep_i;
    logic                     pipeline_empty_i;
    data_word_t               current_pc_i;
    logic                     return_instr_i;
    data_word_t               jump_addr_i;
    data_word_t               mtvec_i;
    logic                     mtvec_we_i;
    logic                     flush_o;
    logic                     stall_o;
    logic                     block_front_end_o;
    pc_redirect_t             redirect_o;
    cause_t                   mcause_o;

    // reference model state.
    data_word_t base;      // value loaded into mtvec, kept word aligned.
    data_word_t exp_mepc;  // resume address of the last trap taken.

    trap_unit dut_i (.*);

    always #4 clk_i = ~clk_i;  // 8 ns period.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model helpers and compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic cause_t make_cause(input logic irq, input cause_code_t code);
        cause_t c;
        c.is_interrupt = irq;
        c.code         = code;
        return c;
    endfunction

    function automatic pc_redirect_t redir(input logic valid, input data_word_t target);
        pc_redirect_t r;
        r.valid  = valid;
        r.target = target;
        return r;
    endfunction

    // exceptions share the base, each interrupt has its own four-byte slot.
    function automatic data_word_t handler_of(input cause_t c);
        if (c.is_interrupt) begin
            return base + data_word_t'(c.code) * 4;
        end
        return base;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // the target only matters when a jump is expected.
    task automatic check_redirect(input string name, input pc_redirect_t got,
                                  input pc_redirect_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.target !== exp.target)) begin
            fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bounded waits, sampled at the falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_redirect(input string what);
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk_i);
            if (redirect_o.valid) return;
        end
        fail_now($sformatf("timeout while waiting for the %s redirect", what));
    endtask

    task automatic wait_block(input logic level, input string what);
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk_i);
            if (block_front_end_o === level) return;
        end
        fail_now($sformatf("timeout while waiting for the front end during %s", what));
    endtask

    // a jump elsewhere is ignored, a jump to mepc goes back to it.
    task automatic check_return();
        @(posedge clk_i);
        return_instr_i <= 1'b1;
        jump_addr_i    <= exp_mepc ^ data_word_t'(4);
        @(negedge clk_i);
        check_redirect("redirect_o", redirect_o, redir(1'b0, '0));
        @(posedge clk_i);
        jump_addr_i <= exp_mepc;
        @(negedge clk_i);
        check_redirect("redirect_o", redirect_o, redir(1'b1, exp_mepc));
        @(posedge clk_i);
        return_instr_i <= 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic take_exception();
        data_word_t  addr;
        cause_code_t code;
        addr = $urandom();
        code = cause_code_t'($urandom());
        @(posedge clk_i);
        exception_i      <= 1'b1;
        exception_addr_i <= addr;
        exception_code_i <= code;
        @(negedge clk_i);  // flush and jump in the same cycle.
        check_flag("flush_o", flush_o, 1'b1);
        check_redirect("redirect_o", redirect_o, redir(1'b1, base));
        @(posedge clk_i);
        exception_i <= 1'b0;
        exp_mepc = addr;
        @(negedge clk_i);
        check_cause("mcause_o", mcause_o, make_cause(1'b0, code));
        check_return();
    endtask

    task automatic fast_irq();
        data_word_t  pc;
        cause_code_t code;
        pc   = $urandom();
        code = cause_code_t'(`TRAP_FAST_IRQ);
        @(posedge clk_i);
        current_pc_i             <= pc;
        irq_i[`TRAP_FAST_IRQ]    <= 1'b1;
        wait_redirect("fast interrupt");
        check_flag("flush_o", flush_o, 1'b1);
        check_redirect("redirect_o", redirect_o, redir(1'b1, handler_of(make_cause(1'b1, code))));
        @(posedge clk_i);
        irq_i <= '0;
        exp_mepc = pc;  // an interrupt resumes at the current pc.
        wait_block(1'b0, "the fast handshake");
        check_cause("mcause_o", mcause_o, make_cause(1'b1, code));
        check_return();
    endtask

    task automatic normal_irq();
        int unsigned line;
        int unsigned hold;
        data_word_t  pc;
        line = $urandom_range(`TRAP_NUM_IRQ - 1, `TRAP_FAST_IRQ + 1);
        hold = $urandom_range(8, 1);
        pc   = $urandom();
        @(posedge clk_i);
        pipeline_empty_i <= 1'b0;
        current_pc_i     <= pc;
        irq_i[line]      <= 1'b1;
        wait_block(1'b1, "a normal request");
        repeat (hold) begin  // still draining, so no jump yet.
            @(negedge clk_i);
            check_flag("block_front_end_o", block_front_end_o, 1'b1);
            check_redirect("redirect_o", redirect_o, redir(1'b0, '0));
        end
        @(posedge clk_i);
        pipeline_empty_i <= 1'b1;
        @(negedge clk_i);
        check_redirect("redirect_o", redirect_o,
                       redir(1'b1, handler_of(make_cause(1'b1, cause_code_t'(line)))));
        @(posedge clk_i);
        irq_i    <= '0;
        exp_mepc = pc;
        wait_block(1'b0, "the normal handshake");
        check_cause("mcause_o", mcause_o, make_cause(1'b1, cause_code_t'(line)));
        check_return();
    endtask

    task automatic several_irqs();
        logic [`TRAP_NUM_IRQ-1:0] mask;
        int unsigned              order[$];  // expected service order.
        cause_t                   c;
        mask                 = `TRAP_NUM_IRQ'($urandom());
        mask[1]              = 1'b1;
        mask[3]              = 1'b1;
        mask[`TRAP_FAST_IRQ] = 1'b0;
        for (int i = 0; i < `TRAP_NUM_IRQ; i++) begin
            if (mask[i]) order.push_back(i);  // the lowest index wins.
        end
        @(posedge clk_i);
        pipeline_empty_i <= 1'b1;
        irq_i            <= mask;
        foreach (order[k]) begin
            c = make_cause(1'b1, cause_code_t'(order[k]));
            wait_redirect("queued interrupt");
            check_redirect("redirect_o", redirect_o, redir(1'b1, handler_of(c)));
            @(negedge clk_i);
            check_cause("mcause_o", mcause_o, c);
        end
        @(posedge clk_i);
        irq_i <= '0;
        wait_block(1'b0, "the last queued handshake");
    endtask

    task automatic sleep_then_irq();
        int unsigned line;
        int unsigned hold;
        line = $urandom_range(`TRAP_NUM_IRQ - 1, 0);
        hold = $urandom_range(6, 1);
        @(posedge clk_i);
        exception_i      <= 1'b1;
        core_sleep_i     <= 1'b1;
        exception_addr_i <= $urandom();
        exception_code_i <= cause_code_t'($urandom());
        @(negedge clk_i);
        check_flag("stall_o", stall_o, 1'b1);
        check_redirect("redirect_o", redirect_o, redir(1'b0, '0));
        @(posedge clk_i);
        exception_i  <= 1'b0;
        core_sleep_i <= 1'b0;
        repeat (hold) begin  // asleep until some interrupt shows up.
            @(negedge clk_i);
            check_flag("stall_o", stall_o, 1'b1);
        end
        @(posedge clk_i);
        irq_i[line] <= 1'b1;
        wait_redirect("wake-up interrupt");
        check_flag("stall_o", stall_o, 1'b0);
        check_redirect("redirect_o", redirect_o,
                       redir(1'b1, handler_of(make_cause(1'b1, cause_code_t'(line)))));
        @(posedge clk_i);
        irq_i <= '0;
        wait_block(1'b0, "the wake-up handshake");
        check_cause("mcause_o", mcause_o, make_cause(1'b1, cause_code_t'(line)));
    endtask

    task automatic exception_with_fast_irq();
        data_word_t  addr;
        cause_code_t code;
        addr = $urandom();
        code = cause_code_t'($urandom());
        @(posedge clk_i);
        irq_i[`TRAP_FAST_IRQ] <= 1'b1;
        repeat (ARB_LATENCY) @(posedge clk_i);
        exception_i      <= 1'b1;  // lands in the cycle the fast request is offered.
        exception_addr_i <= addr;
        exception_code_i <= code;
        @(negedge clk_i);
        check_redirect("redirect_o", redirect_o,
                       redir(1'b1, handler_of(make_cause(1'b1, cause_code_t'(`TRAP_FAST_IRQ)))));
        @(posedge clk_i);
        exception_i <= 1'b0;
        irq_i       <= '0;
        wait_redirect("kept exception");
        check_redirect("redirect_o", redirect_o, redir(1'b1, base));
        @(negedge clk_i);
        check_cause("mcause_o", mcause_o, make_cause(1'b0, code));
        exp_mepc = addr;
        check_return();
    endtask

    initial begin
        void'($urandom(26));
        rst_n_i          = 1'b0;
        irq_i            = '0;
        exception_i      = 1'b0;
        exception_addr_i = '0;
        exception_code_i = '0;
        core_sleep_i     = 1'b0;
        pipeline_empty_i = 1'b1;
        current_pc_i     = '0;
        return_instr_i   = 1'b0;
        jump_addr_i      = '0;
        mtvec_i          = '0;
        mtvec_we_i       = 1'b0;
        base             = data_word_t'($urandom()) & ~data_word_t'(3);
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);  // everything quiet and cleared out of reset.
        check_flag("flush_o", flush_o, 1'b0);
        check_flag("stall_o", stall_o, 1'b0);
        check_flag("block_front_end_o", block_front_end_o, 1'b0);
        check_redirect("redirect_o", redirect_o, redir(1'b0, '0));
        check_cause("mcause_o", mcause_o, make_cause(1'b0, '0));
        @(posedge clk_i);
        mtvec_i    <= base;
        mtvec_we_i <= 1'b1;
        @(posedge clk_i);
        mtvec_we_i <= 1'b0;
        repeat (4) take_exception();
        fast_irq();
        repeat (3) normal_irq();
        several_irqs();
        sleep_then_irq();
        exception_with_fast_irq();
        $display("all tests passed");
        $finish;
    end

endmodule : trap_unit_tb

//--- files.f
+incdir+common
common/trap_pkg.sv
hdl/irq_arbiter.sv
trap/trap_csr.sv
trap/trap_manager.sv
hdl/trap_unit.sv
testbench/trap_unit_chk.sv
testbench/trap_unit_tb.sv

//--- Bender.yml
package:
  name: trap_unit

sources:
  - include_dirs:
      - common
    files:
      - common/trap_pkg.sv
      - hdl/irq_arbiter.sv
      - trap/trap_csr.sv
      - trap/trap_manager.sv
      - hdl/trap_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/trap_unit_chk.sv
      - testbench/trap_unit_tb.sv
